//--- source/stamofu_pkg.sv
// shared widths and bundles for the store/AMO/fence issue queue; bank of a PR is its low bits
`default_nettype none

package stamofu_pkg;

	// ------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------
	localparam int PR_COUNT = 128;
	localparam int LOG_PR_COUNT = $clog2(PR_COUNT);
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);
	localparam int LOG_ROB_ENTRIES = 6;
	localparam int LOG_STAMOFU_CQ_ENTRIES = 4;
	localparam int MDPT_INFO_WIDTH = 8;
	localparam int STAMOFU_IQ_ENTRIES = 8;
	localparam int LOG_STAMOFU_IQ_ENTRIES = $clog2(STAMOFU_IQ_ENTRIES);

	// ------------------------------------------------------------
	// plain vector types
	// ------------------------------------------------------------
	typedef logic [LOG_PR_COUNT-1:0] pr_t;
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
	typedef logic [LOG_ROB_ENTRIES-1:0] rob_index_t;
	typedef logic [LOG_STAMOFU_CQ_ENTRIES-1:0] cq_index_t;
	typedef logic [MDPT_INFO_WIDTH-1:0] mdp_info_t;
	typedef logic [3:0] op_code_t;
	typedef logic [11:0] imm12_t;

	// ------------------------------------------------------------
	// bundles
	// ------------------------------------------------------------

	// op as it comes from dispatch and sits in the queue
	typedef struct packed {
		logic is_store;
		logic is_amo;
		logic is_fence;
		op_code_t op;
		imm12_t imm12;
		mdp_info_t mdp_info;
		logic mem_aq;
		logic io_aq;
		pr_t A_PR;
		logic A_ready;
		logic A_is_zero;
		pr_t B_PR;
		logic B_ready;
		logic B_is_zero;
		rob_index_t ROB_index;
		cq_index_t cq_index;
	} stamofu_op_t;

	// one writeback cycle, indexed by bank
	typedef struct packed {
		logic [PRF_BANK_COUNT-1:0] valid;
		upper_pr_t [PRF_BANK_COUNT-1:0] upper_pr;
	} wb_bus_t;

	typedef struct packed {
		logic is_store;
		logic is_amo;
		logic is_fence;
		op_code_t op;
		imm12_t imm12;
		mdp_info_t mdp_info;
		logic mem_aq;
		logic io_aq;
		logic A_forward;
		logic A_is_zero;
		bank_t A_bank;
		logic B_forward;
		logic B_is_zero;
		bank_t B_bank;
		rob_index_t ROB_index;
		cq_index_t cq_index;
	} stamofu_issue_t;

	typedef struct packed {
		logic A_valid;
		pr_t A_PR;
		logic B_valid;
		pr_t B_PR;
	} prf_req_t;

	// true when the writeback cycle writes this PR
	function automatic logic wb_match(input wb_bus_t wb, input pr_t pr);
		bank_t bank;
		upper_pr_t upper;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		upper = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
		return wb.valid[bank] && (wb.upper_pr[bank] == upper);
	endfunction

endpackage

`default_nettype wire

//--- source/stamofu_enq_stage.sv
// input registers; dispatch must hold enq_op until enq_valid and enq_ready meet on an edge
`default_nettype none
`timescale 1ns/1ps

module stamofu_enq_stage (
	input logic CLK,
	input logic nRST,

	// dispatch side
	input logic enq_valid,
	input stamofu_pkg::stamofu_op_t enq_op,
	input logic enq_ready,

	// writeback bus, no handshake
	input stamofu_pkg::wb_bus_t wb_bus,

	// toward the queue
	output logic cap_valid,
	output stamofu_pkg::stamofu_op_t cap_op,
	output stamofu_pkg::wb_bus_t wb_q
);

	logic accept;
	logic a_wake;
	logic b_wake;
	stamofu_pkg::stamofu_op_t op_woken;

	assign accept = enq_valid & enq_ready;

	// ------------------------------------------------------------
	// wakeup of the op being captured
	// ------------------------------------------------------------

	// the queue only sees wb_q one cycle later, so a writeback on the
	// capture edge would otherwise slip past this op
	assign a_wake = stamofu_pkg::wb_match(wb_bus, enq_op.A_PR);
	assign b_wake = stamofu_pkg::wb_match(wb_bus, enq_op.B_PR);

	always_comb begin
		op_woken = enq_op;
		op_woken.A_ready = enq_op.A_ready | a_wake;
		op_woken.B_ready = enq_op.B_ready | b_wake;
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @ (posedge CLK, negedge nRST) begin
		if (~nRST) begin
			cap_valid <= 1'b0;
			wb_q <= '0;
		end
		else begin
			cap_valid <= accept;
			wb_q <= wb_bus;
		end
	end

	// captured op payload
	always_ff @ (posedge CLK) begin
		if (accept) begin
			cap_op <= op_woken;
		end
	end

endmodule

`default_nettype wire

//--- source/stamofu_iq.sv
// age-ordered compacting queue, slot 0 oldest; relies on enq_ready to keep cap_valid off when full
`default_nettype none
`timescale 1ns/1ps

module stamofu_iq (
	input logic CLK,
	input logic nRST,

	// captured op and registered writeback
	input logic cap_valid,
	input stamofu_pkg::stamofu_op_t cap_op,
	input stamofu_pkg::wb_bus_t wb_q,

	// output side
	input logic issue_ready,

	output logic enq_ready,
	output logic sel_valid,
	output stamofu_pkg::stamofu_issue_t sel_issue,
	output stamofu_pkg::prf_req_t sel_prf_req
);

	// occupancy 0..entries and slot index
	typedef logic [stamofu_pkg::LOG_STAMOFU_IQ_ENTRIES:0] count_t;
	typedef logic [stamofu_pkg::LOG_STAMOFU_IQ_ENTRIES-1:0] idx_t;

	// queue state
	count_t count_q;
	stamofu_pkg::stamofu_op_t op_q [stamofu_pkg::STAMOFU_IQ_ENTRIES];

	// per-entry wakeup
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] entry_valid;
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] a_match;
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] b_match;
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] a_usable;
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] b_usable;
	logic [stamofu_pkg::STAMOFU_IQ_ENTRIES-1:0] selectable;
	stamofu_pkg::stamofu_op_t op_woken [stamofu_pkg::STAMOFU_IQ_ENTRIES];

	// select
	idx_t sel_idx;
	stamofu_pkg::stamofu_op_t sel_op;
	logic sel_a_fwd;
	logic sel_b_fwd;

	// update
	logic deq;
	count_t count_after_deq;
	count_t count_next;
	stamofu_pkg::stamofu_op_t op_shift [stamofu_pkg::STAMOFU_IQ_ENTRIES];
	stamofu_pkg::stamofu_op_t op_next [stamofu_pkg::STAMOFU_IQ_ENTRIES];

	// ------------------------------------------------------------
	// wakeup
	// ------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < stamofu_pkg::STAMOFU_IQ_ENTRIES; i++) begin
			// entries are packed toward slot 0
			entry_valid[i] = count_q > count_t'(i);
			a_match[i] = stamofu_pkg::wb_match(wb_q, op_q[i].A_PR);
			b_match[i] = stamofu_pkg::wb_match(wb_q, op_q[i].B_PR);
			a_usable[i] = op_q[i].A_ready | op_q[i].A_is_zero | a_match[i];
			b_usable[i] = op_q[i].B_ready | op_q[i].B_is_zero | b_match[i];
			selectable[i] = entry_valid[i] & a_usable[i] & b_usable[i];

			// ready bits stick once the tag has gone by
			op_woken[i] = op_q[i];
			op_woken[i].A_ready = op_q[i].A_ready | a_match[i];
			op_woken[i].B_ready = op_q[i].B_ready | b_match[i];
		end
	end

	// ------------------------------------------------------------
	// oldest-ready select
	// ------------------------------------------------------------

	// scan young to old so the lowest slot wins
	always_comb begin
		sel_valid = 1'b0;
		sel_idx = '0;
		for (int i = stamofu_pkg::STAMOFU_IQ_ENTRIES - 1; i >= 0; i--) begin
			if (selectable[i]) begin
				sel_valid = 1'b1;
				sel_idx = idx_t'(i);
			end
		end
	end

	assign sel_op = op_q[sel_idx];

	// forwarded only if the wb_q match is what made it usable
	assign sel_a_fwd = a_match[sel_idx] & ~sel_op.A_ready & ~sel_op.A_is_zero;
	assign sel_b_fwd = b_match[sel_idx] & ~sel_op.B_ready & ~sel_op.B_is_zero;

	always_comb begin
		sel_issue.is_store = sel_op.is_store;
		sel_issue.is_amo = sel_op.is_amo;
		sel_issue.is_fence = sel_op.is_fence;
		sel_issue.op = sel_op.op;
		sel_issue.imm12 = sel_op.imm12;
		sel_issue.mdp_info = sel_op.mdp_info;
		sel_issue.mem_aq = sel_op.mem_aq;
		sel_issue.io_aq = sel_op.io_aq;
		sel_issue.A_forward = sel_a_fwd;
		sel_issue.A_is_zero = sel_op.A_is_zero;
		sel_issue.A_bank = sel_op.A_PR[stamofu_pkg::LOG_PRF_BANK_COUNT-1:0];
		sel_issue.B_forward = sel_b_fwd;
		sel_issue.B_is_zero = sel_op.B_is_zero;
		sel_issue.B_bank = sel_op.B_PR[stamofu_pkg::LOG_PRF_BANK_COUNT-1:0];
		sel_issue.ROB_index = sel_op.ROB_index;
		sel_issue.cq_index = sel_op.cq_index;
	end

	// PRF read only for operands not zero and not on the bypass
	always_comb begin
		sel_prf_req.A_valid = sel_valid & ~sel_op.A_is_zero & ~sel_a_fwd;
		sel_prf_req.A_PR = sel_op.A_PR;
		sel_prf_req.B_valid = sel_valid & ~sel_op.B_is_zero & ~sel_b_fwd;
		sel_prf_req.B_PR = sel_op.B_PR;
	end

	// ------------------------------------------------------------
	// dequeue, compaction and append
	// ------------------------------------------------------------
	assign deq = sel_valid & issue_ready;
	assign count_after_deq = count_q - count_t'(deq);
	assign count_next = count_after_deq + count_t'(cap_valid);

	// one-slot-down view of the queue
	always_comb begin
		for (int i = 0; i < stamofu_pkg::STAMOFU_IQ_ENTRIES - 1; i++) begin
			op_shift[i] = op_woken[i + 1];
		end
		op_shift[stamofu_pkg::STAMOFU_IQ_ENTRIES - 1] =
			op_woken[stamofu_pkg::STAMOFU_IQ_ENTRIES - 1];
	end

	always_comb begin
		for (int i = 0; i < stamofu_pkg::STAMOFU_IQ_ENTRIES; i++) begin
			// slots at and above the leaving entry move down by one
			if (deq && (idx_t'(i) >= sel_idx)) begin
				op_next[i] = op_shift[i];
			end
			else begin
				op_next[i] = op_woken[i];
			end
			// new op goes right behind the youngest survivor
			if (cap_valid && (count_t'(i) == count_after_deq)) begin
				op_next[i] = cap_op;
			end
		end
	end

	always_ff @ (posedge CLK) begin
		for (int i = 0; i < stamofu_pkg::STAMOFU_IQ_ENTRIES; i++) begin
			op_q[i] <= op_next[i];
		end
	end

	// ------------------------------------------------------------
	// occupancy and enqueue ready
	// ------------------------------------------------------------

	// two free slots: one may already be in flight in the capture reg
	always_ff @ (posedge CLK, negedge nRST) begin
		if (~nRST) begin
			count_q <= '0;
			enq_ready <= 1'b0;
		end
		else begin
			count_q <= count_next;
			enq_ready <= count_next <= count_t'(stamofu_pkg::STAMOFU_IQ_ENTRIES - 2);
		end
	end

endmodule

`default_nettype wire

//--- source/stamofu_issue_stage.sv
// output register; a held bundle keeps its fields but its PRF request valids drop after one cycle
`default_nettype none
`timescale 1ns/1ps

module stamofu_issue_stage (
	input logic CLK,
	input logic nRST,

	// from the queue select
	input logic sel_valid,
	input stamofu_pkg::stamofu_issue_t sel_issue,
	input stamofu_pkg::prf_req_t sel_prf_req,

	// pipeline feedback
	input logic pipeline_ready,

	output logic issue_ready,
	output logic issue_valid,
	output stamofu_pkg::stamofu_issue_t issue,
	output stamofu_pkg::prf_req_t prf_req
);

	logic a_req_valid;
	logic b_req_valid;
	stamofu_pkg::pr_t a_req_pr;
	stamofu_pkg::pr_t b_req_pr;

	// empty, or the current bundle leaves on this edge
	assign issue_ready = ~issue_valid | pipeline_ready;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_ff @ (posedge CLK, negedge nRST) begin
		if (~nRST) begin
			issue_valid <= 1'b0;
			a_req_valid <= 1'b0;
			b_req_valid <= 1'b0;
		end
		else if (issue_ready) begin
			issue_valid <= sel_valid;
			a_req_valid <= sel_prf_req.A_valid;
			b_req_valid <= sel_prf_req.B_valid;
		end
		else begin
			// stalled: PRF already read on the first cycle
			a_req_valid <= 1'b0;
			b_req_valid <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// payload
	// ------------------------------------------------------------
	always_ff @ (posedge CLK) begin
		if (issue_ready) begin
			issue <= sel_issue;
			a_req_pr <= sel_prf_req.A_PR;
			b_req_pr <= sel_prf_req.B_PR;
		end
	end

	assign prf_req = '{
		A_valid: a_req_valid,
		A_PR: a_req_pr,
		B_valid: b_req_valid,
		B_PR: b_req_pr
	};

endmodule

`default_nettype wire

//--- source/stamofu_iq_top.sv
// store/AMO/fence issue queue; best case two edges from accepted enqueue to issue_valid
`default_nettype none
`timescale 1ns/1ps

module stamofu_iq_top (
	input logic CLK,
	input logic nRST,

	// dispatch
	input logic enq_valid,
	input stamofu_pkg::stamofu_op_t enq_op,
	output logic enq_ready,

	// writeback
	input stamofu_pkg::wb_bus_t wb_bus,

	// pipeline and PRF
	output logic issue_valid,
	output stamofu_pkg::stamofu_issue_t issue,
	output stamofu_pkg::prf_req_t prf_req,
	input logic pipeline_ready
);

	// input side to queue
	logic cap_valid;
	stamofu_pkg::stamofu_op_t cap_op;
	stamofu_pkg::wb_bus_t wb_q;

	// queue to output side
	logic sel_valid;
	stamofu_pkg::stamofu_issue_t sel_issue;
	stamofu_pkg::prf_req_t sel_prf_req;
	logic issue_ready;

	stamofu_enq_stage u_enq_stage (
		.CLK (CLK),
		.nRST (nRST),
		.enq_valid (enq_valid),
		.enq_op (enq_op),
		.enq_ready (enq_ready),
		.wb_bus (wb_bus),
		.cap_valid (cap_valid),
		.cap_op (cap_op),
		.wb_q (wb_q)
	);

	stamofu_iq u_iq (
		.CLK (CLK),
		.nRST (nRST),
		.cap_valid (cap_valid),
		.cap_op (cap_op),
		.wb_q (wb_q),
		.issue_ready (issue_ready),
		.enq_ready (enq_ready),
		.sel_valid (sel_valid),
		.sel_issue (sel_issue),
		.sel_prf_req (sel_prf_req)
	);

	stamofu_issue_stage u_issue_stage (
		.CLK (CLK),
		.nRST (nRST),
		.sel_valid (sel_valid),
		.sel_issue (sel_issue),
		.sel_prf_req (sel_prf_req),
		.pipeline_ready (pipeline_ready),
		.issue_ready (issue_ready),
		.issue_valid (issue_valid),
		.issue (issue),
		.prf_req (prf_req)
	);

endmodule

`default_nettype wire

//--- testbench/stamofu_iq_tb.sv
// directed tests for the stamofu issue queue; each test expects an empty queue and output reg at start
`default_nettype none
`timescale 1ns/1ps

module stamofu_iq_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT = 40;
	localparam int HOLD_CYCLES = 12;
	localparam int BURST_OPS = 6;
	localparam int MAX_PUSH = 16;
	// rough cycle budget of the five tests
	localparam int TEST_CYCLES = 10 + 30 + 30 + 10 + 80;
	localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 200) * CLK_PERIOD;

	logic CLK;
	logic nRST;
	logic enq_valid;
	stamofu_pkg::stamofu_op_t enq_op;
	logic enq_ready;
	stamofu_pkg::wb_bus_t wb_bus;
	logic issue_valid;
	stamofu_pkg::stamofu_issue_t issue;
	stamofu_pkg::prf_req_t prf_req;
	logic pipeline_ready;

	int error_count;

	stamofu_iq_top u_stamofu_iq_top (
		.CLK (CLK),
		.nRST (nRST),
		.enq_valid (enq_valid),
		.enq_op (enq_op),
		.enq_ready (enq_ready),
		.wb_bus (wb_bus),
		.issue_valid (issue_valid),
		.issue (issue),
		.prf_req (prf_req),
		.pipeline_ready (pipeline_ready)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ------------------------------------------------------------
	// reference model of ops and bundles
	// ------------------------------------------------------------

	// dispatch marks both operands of a fence as zero
	function automatic stamofu_pkg::stamofu_op_t random_op(input logic a_ready,
		input logic b_ready, input logic allow_zero);
		stamofu_pkg::stamofu_op_t op;
		int unsigned kind;
		kind = $urandom_range(allow_zero ? 2 : 1);
		op.is_store = (kind == 0);
		op.is_amo = (kind == 1);
		op.is_fence = (kind == 2);
		op.op = stamofu_pkg::op_code_t'($urandom);
		op.imm12 = stamofu_pkg::imm12_t'($urandom);
		op.mdp_info = stamofu_pkg::mdp_info_t'($urandom);
		op.mem_aq = 1'($urandom);
		op.io_aq = 1'($urandom);
		op.A_PR = stamofu_pkg::pr_t'($urandom);
		op.A_ready = a_ready;
		op.A_is_zero = allow_zero && (kind == 2 || $urandom_range(3) == 0);
		op.B_PR = stamofu_pkg::pr_t'($urandom);
		op.B_ready = b_ready;
		op.B_is_zero = allow_zero && (kind == 2 || $urandom_range(3) == 0);
		op.ROB_index = stamofu_pkg::rob_index_t'($urandom);
		op.cq_index = stamofu_pkg::cq_index_t'($urandom);
		return op;
	endfunction

	function automatic stamofu_pkg::stamofu_issue_t expected_issue(
		input stamofu_pkg::stamofu_op_t op, input logic a_fwd, input logic b_fwd);
		stamofu_pkg::stamofu_issue_t bundle;
		bundle.is_store = op.is_store;
		bundle.is_amo = op.is_amo;
		bundle.is_fence = op.is_fence;
		bundle.op = op.op;
		bundle.imm12 = op.imm12;
		bundle.mdp_info = op.mdp_info;
		bundle.mem_aq = op.mem_aq;
		bundle.io_aq = op.io_aq;
		bundle.A_forward = a_fwd;
		bundle.A_is_zero = op.A_is_zero;
		bundle.A_bank = op.A_PR[stamofu_pkg::LOG_PRF_BANK_COUNT-1:0];
		bundle.B_forward = b_fwd;
		bundle.B_is_zero = op.B_is_zero;
		bundle.B_bank = op.B_PR[stamofu_pkg::LOG_PRF_BANK_COUNT-1:0];
		bundle.ROB_index = op.ROB_index;
		bundle.cq_index = op.cq_index;
		return bundle;
	endfunction

	// bank k with upper u writes PR {u,k}
	function automatic stamofu_pkg::wb_bus_t writeback_of(input stamofu_pkg::pr_t pr);
		stamofu_pkg::wb_bus_t wb;
		stamofu_pkg::bank_t bank;
		wb = '0;
		bank = pr[stamofu_pkg::LOG_PRF_BANK_COUNT-1:0];
		wb.valid[bank] = 1'b1;
		wb.upper_pr[bank] = pr[stamofu_pkg::LOG_PR_COUNT-1:stamofu_pkg::LOG_PRF_BANK_COUNT];
		return wb;
	endfunction

	// ------------------------------------------------------------
	// checks and drivers
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("%s at %0t", what, $time);
	endtask

	// first_cycle low means a held bundle with no PRF read expected
	task automatic compare_bundle(input stamofu_pkg::stamofu_op_t op, input logic a_fwd,
		input logic b_fwd, input logic first_cycle);
		logic a_req;
		logic b_req;
		a_req = first_cycle & ~op.A_is_zero & ~a_fwd;
		b_req = first_cycle & ~op.B_is_zero & ~b_fwd;
		check_value("issue_valid", 64'(issue_valid), 64'(1'b1));
		check_value("issue", 64'(issue), 64'(expected_issue(op, a_fwd, b_fwd)));
		check_value("prf_req.A_valid", 64'(prf_req.A_valid), 64'(a_req));
		check_value("prf_req.B_valid", 64'(prf_req.B_valid), 64'(b_req));
		if (a_req) begin
			check_value("prf_req.A_PR", 64'(prf_req.A_PR), 64'(op.A_PR));
		end
		if (b_req) begin
			check_value("prf_req.B_PR", 64'(prf_req.B_PR), 64'(op.B_PR));
		end
	endtask

	task automatic wait_issue(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			seen = (issue_valid === 1'b1);
			cycles++;
		end
		if (!seen) begin
			report_failure("issue_valid never rose while waiting for an op");
		end
	endtask

	task automatic expect_issue(input stamofu_pkg::stamofu_op_t op, input logic a_fwd,
		input logic b_fwd);
		logic seen;
		wait_issue(seen);
		if (seen) begin
			compare_bundle(op, a_fwd, b_fwd, 1'b1);
		end
	endtask

	// returns on the falling edge just before the accepting rising edge
	task automatic send_op(input stamofu_pkg::stamofu_op_t op, input stamofu_pkg::wb_bus_t wb);
		int cycles;
		@(negedge CLK);
		enq_valid = 1'b1;
		enq_op = op;
		wb_bus = wb;
		cycles = 0;
		while (enq_ready !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		if (enq_ready !== 1'b1) begin
			report_failure("enq_ready stayed low and the op was never accepted");
		end
	endtask

	task automatic stop_enqueue();
		@(negedge CLK);
		enq_valid = 1'b0;
		wb_bus = '0;
	endtask

	// capture, queue write, then output register
	task automatic issue_two_edges_later(input stamofu_pkg::stamofu_op_t op);
		stop_enqueue();
		check_value("issue_valid", 64'(issue_valid), 64'(1'b0));
		@(negedge CLK);
		check_value("issue_valid", 64'(issue_valid), 64'(1'b0));
		@(negedge CLK);
		compare_bundle(op, 1'b0, 1'b0, 1'b1);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_and_single();
		stamofu_pkg::stamofu_op_t op;
		check_value("enq_ready", 64'(enq_ready), 64'(1'b0));
		check_value("issue_valid", 64'(issue_valid), 64'(1'b0));
		check_value("prf_req.A_valid", 64'(prf_req.A_valid), 64'(1'b0));
		check_value("prf_req.B_valid", 64'(prf_req.B_valid), 64'(1'b0));
		op = random_op(1'b1, 1'b1, 1'b0);
		send_op(op, '0);
		issue_two_edges_later(op);
	endtask

	task automatic test_in_order_burst();
		stamofu_pkg::stamofu_op_t ops [BURST_OPS];
		for (int k = 0; k < BURST_OPS; k++) begin
			ops[k] = random_op(1'b1, 1'b1, 1'b1);
		end
		fork
			begin
				for (int k = 0; k < BURST_OPS; k++) begin
					send_op(ops[k], '0);
				end
				stop_enqueue();
			end
			begin
				for (int k = 0; k < BURST_OPS; k++) begin
					expect_issue(ops[k], 1'b0, 1'b0);
				end
			end
		join
	endtask

	task automatic test_wakeup_bypass();
		stamofu_pkg::stamofu_op_t older;
		stamofu_pkg::stamofu_op_t younger;
		older = random_op(1'b1, 1'b0, 1'b0);
		younger = random_op(1'b1, 1'b1, 1'b0);
		send_op(older, '0);
		send_op(younger, '0);
		stop_enqueue();
		expect_issue(younger, 1'b0, 1'b0);
		@(negedge CLK);
		wb_bus = writeback_of(older.B_PR);
		@(negedge CLK);
		wb_bus = '0;
		check_value("issue_valid", 64'(issue_valid), 64'(1'b0));
		@(negedge CLK);
		compare_bundle(older, 1'b0, 1'b1, 1'b1);
	endtask

	task automatic test_capture_wakeup();
		stamofu_pkg::stamofu_op_t op;
		op = random_op(1'b1, 1'b0, 1'b0);
		send_op(op, writeback_of(op.B_PR));
		issue_two_edges_later(op);
	endtask

	task automatic test_backpressure();
		stamofu_pkg::stamofu_op_t ops [MAX_PUSH];
		int sent;
		logic seen;
		for (int k = 0; k < MAX_PUSH; k++) begin
			ops[k] = random_op(1'b1, 1'b1, 1'b1);
		end
		sent = 0;
		@(negedge CLK);
		pipeline_ready = 1'b0;
		fork
			begin
				for (int k = 0; k < MAX_PUSH; k++) begin
					@(negedge CLK);
					if (enq_ready !== 1'b1) begin
						enq_valid = 1'b0;
						break;
					end
					enq_valid = 1'b1;
					enq_op = ops[k];
					sent++;
				end
				@(negedge CLK);
				enq_valid = 1'b0;
			end
			begin
				wait_issue(seen);
				if (seen) begin
					compare_bundle(ops[0], 1'b0, 1'b0, 1'b1);
					repeat (HOLD_CYCLES) begin
						@(negedge CLK);
						compare_bundle(ops[0], 1'b0, 1'b0, 1'b0);
					end
				end
			end
		join
		// output register plus a full queue
		check_value("accepted op count", 64'(sent), 64'(stamofu_pkg::STAMOFU_IQ_ENTRIES + 1));
		check_value("enq_ready", 64'(enq_ready), 64'(1'b0));
		pipeline_ready = 1'b1;
		for (int k = 1; k < sent; k++) begin
			expect_issue(ops[k], 1'b0, 1'b0);
		end
		@(negedge CLK);
		check_value("issue_valid", 64'(issue_valid), 64'(1'b0));
	endtask

	// ------------------------------------------------------------
	// run control
	// ------------------------------------------------------------
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished, %0d error(s) so far", error_count);
		$display("Regression failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h3933760b));
		error_count = 0;
		CLK = 1'b0;
		nRST = 1'b0;
		enq_valid = 1'b0;
		enq_op = '0;
		wb_bus = '0;
		pipeline_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge CLK);
		nRST = 1'b1;

		test_reset_and_single();
		test_in_order_burst();
		test_wakeup_bypass();
		test_capture_wakeup();
		test_backpressure();

		$display("all tests done, %0d error(s)", error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end
		else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/stamofu_pkg.sv
source/stamofu_enq_stage.sv
source/stamofu_iq.sv
source/stamofu_issue_stage.sv
source/stamofu_iq_top.sv
testbench/stamofu_iq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= stamofu_iq_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when the file list or a source is newer than the binary
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code does not
run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
